/* all.f */
+incdir+testbench
design/decode_pkg.sv
design/ctrl_decode.sv
design/imm_gen.sv
design/operand_select.sv
design/inst_decode.sv
testbench/tb_inst_decode.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_inst_decode -f all.f \
    && ./obj_dir/Vtb_inst_decode | tee /dev/stderr | grep -qF "Regression passed" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation did not pass"; exit 1; }

/* testbench/decode_checks.svh */
// compare tasks, one per result type

task automatic check_word(string name, xlen_t got, xlen_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] t=%0t %s got 0x%08h expected 0x%08h",
                            $time, name, got, exp));
    end
endtask

task automatic check_addr(string name, reg_addr_t got, reg_addr_t exp);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] t=%0t %s got x%0d expected x%0d",
                            $time, name, got, exp));
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b",
                            $time, name, got, exp));
    end
endtask

// instruction encoders, field order as in the RV32I base formats

function automatic inst_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_R_TYPE};
endfunction

function automatic inst_t enc_i(logic [6:0] opc, logic [11:0] imm, reg_addr_t rs1,
                                logic [2:0] f3, reg_addr_t rd);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic inst_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

// imm[0] is not encoded
function automatic inst_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic inst_t enc_u(logic [6:0] opc, logic [19:0] imm, reg_addr_t rd);
    return {imm, rd, opc};
endfunction

function automatic inst_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// sign extension of the raw immediate values
function automatic xlen_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
endfunction

function automatic xlen_t sext13(logic [12:0] imm);
    return {{19{imm[12]}}, imm};
endfunction

function automatic xlen_t sext21(logic [20:0] imm);
    return {{11{imm[20]}}, imm};
endfunction

/* testbench/tb_inst_decode.sv */
`timescale 1ns/1ps

module tb_inst_decode
    import decode_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 1500;

    logic      clk;
    logic      arst_n;
    logic      inst_valid;
    inst_t     inst_word;
    xlen_t     inst_addr;
    xlen_t     reg1_rdata;
    xlen_t     reg2_rdata;
    logic      ex_jump_flag;
    reg_addr_t reg1_raddr;
    reg_addr_t reg2_raddr;
    logic      valid;
    logic      reg_wen;
    reg_addr_t reg_waddr;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     op1_jump;
    xlen_t     op2_jump;
    inst_t     inst_out;
    xlen_t     inst_addr_out;

    // register file model, read combinationally
    xlen_t     rf [32];
    integer    seed;
    int        cycles = 0;

    inst_decode i_inst_decode (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .inst_valid_i   (inst_valid),
        .inst_i         (inst_word),
        .inst_addr_i    (inst_addr),
        .reg1_rdata_i   (reg1_rdata),
        .reg2_rdata_i   (reg2_rdata),
        .ex_jump_flag_i (ex_jump_flag),
        .reg1_raddr_o   (reg1_raddr),
        .reg2_raddr_o   (reg2_raddr),
        .valid_o        (valid),
        .reg_wen_o      (reg_wen),
        .reg_waddr_o    (reg_waddr),
        .op1_o          (op1),
        .op2_o          (op2),
        .op1_jump_o     (op1_jump),
        .op2_jump_o     (op2_jump),
        .inst_o         (inst_out),
        .inst_addr_o    (inst_addr_out)
    );

    assign reg1_rdata = rf[reg1_raddr];
    assign reg2_rdata = rf[reg2_raddr];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "stopping at first error");
    endtask

    `include "decode_checks.svh"

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: tests still running after %0d cycles", cycles));
        end
    end

    task automatic check_result(logic exp_valid, logic exp_wen, reg_addr_t exp_waddr,
                                xlen_t exp_op1, xlen_t exp_op2,
                                xlen_t exp_j1, xlen_t exp_j2);
        check_bit("valid_o", valid, exp_valid);
        check_bit("reg_wen_o", reg_wen, exp_wen);
        check_addr("reg_waddr_o", reg_waddr, exp_waddr);
        check_word("op1_o", op1, exp_op1);
        check_word("op2_o", op2, exp_op2);
        check_word("op1_jump_o", op1_jump, exp_j1);
        check_word("op2_jump_o", op2_jump, exp_j2);
    endtask

    // one instruction alone: read addresses in its cycle, outputs one cycle later
    task automatic run_one(inst_t word, xlen_t pc, logic flush,
                           reg_addr_t exp_r1, reg_addr_t exp_r2,
                           logic exp_valid, logic exp_wen, reg_addr_t exp_waddr,
                           xlen_t exp_op1, xlen_t exp_op2, xlen_t exp_j1, xlen_t exp_j2);
        @(posedge clk);
        inst_valid   <= 1'b1;
        inst_word    <= word;
        inst_addr    <= pc;
        ex_jump_flag <= flush;
        @(negedge clk);
        check_addr("reg1_raddr_o", reg1_raddr, exp_r1);
        check_addr("reg2_raddr_o", reg2_raddr, exp_r2);
        @(posedge clk);
        inst_valid   <= 1'b0;
        ex_jump_flag <= 1'b0;
        @(negedge clk);
        check_result(exp_valid, exp_wen, exp_waddr, exp_op1, exp_op2, exp_j1, exp_j2);
        check_word("inst_o", inst_out, word);
        check_word("inst_addr_o", inst_addr_out, pc);
    endtask

    task automatic test_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_result(1'b0, 1'b0, '0, '0, '0, '0, '0);
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_result(1'b0, 1'b0, '0, '0, '0, '0, '0);
    endtask

    task automatic test_alu();
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic [2:0]  f3;
        logic [11:0] imm;
        xlen_t       pc;
        for (int n = 0; n < 8; n++) begin
            rs1 = reg_addr_t'($random(seed));
            rs2 = reg_addr_t'($random(seed));
            rd  = reg_addr_t'($random(seed));
            f3  = 3'($random(seed));
            imm = 12'($random(seed));
            pc  = xlen_t'($random(seed)) & ~32'h3;
            run_one(enc_r((n % 2) ? 7'h20 : 7'h00, rs2, rs1, f3, rd), pc, 1'b0,
                    rs1, rs2, 1'b1, 1'b1, rd, rf[rs1], rf[rs2], '0, '0);
            run_one(enc_i(OPC_I_TYPE, imm, rs1, f3, rd), pc + INST_LEN, 1'b0,
                    rs1, '0, 1'b1, 1'b1, rd, rf[rs1], sext12(imm), '0, '0);
        end
        // x0 as source and destination, still reads zero
        run_one(enc_r(7'h00, rs2, 5'd0, 3'b000, 5'd0), pc, 1'b0,
                5'd0, rs2, 1'b1, 1'b1, 5'd0, 32'h0, rf[rs2], '0, '0);
    endtask

    task automatic test_load_store();
        logic [2:0]  load_f3 [5];
        logic [2:0]  store_f3 [3];
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        logic [11:0] imm;
        xlen_t       pc;
        load_f3  = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};
        store_f3 = '{F3_SB, F3_SH, F3_SW};
        for (int n = 0; n < 5; n++) begin
            rs1     = reg_addr_t'($random(seed));
            rd      = reg_addr_t'($random(seed));
            imm     = 12'($random(seed));
            imm[11] = n[0];
            pc      = xlen_t'($random(seed)) & ~32'h3;
            run_one(enc_i(OPC_LOAD, imm, rs1, load_f3[n], rd), pc, 1'b0,
                    rs1, '0, 1'b1, 1'b1, rd, rf[rs1], sext12(imm), '0, '0);
        end
        for (int n = 0; n < 3; n++) begin
            rs1     = reg_addr_t'($random(seed));
            rs2     = reg_addr_t'($random(seed));
            imm     = 12'($random(seed));
            imm[11] = ~n[0];
            pc      = xlen_t'($random(seed)) & ~32'h3;
            run_one(enc_s(imm, rs2, rs1, store_f3[n]), pc, 1'b0,
                    rs1, rs2, 1'b1, 1'b0, '0, rf[rs1], sext12(imm), '0, '0);
        end
    endtask

    task automatic test_jumps();
        logic [2:0]  branch_f3 [6];
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        reg_addr_t   rd2;
        logic [12:0] bimm;
        logic [20:0] jimm;
        logic [11:0] imm;
        xlen_t       pc;
        branch_f3 = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int n = 0; n < 6; n++) begin
            rs1  = reg_addr_t'($random(seed));
            rs2  = reg_addr_t'($random(seed));
            bimm = 13'($random(seed)) & ~13'h1;
            pc   = xlen_t'($random(seed)) & ~32'h3;
            run_one(enc_b(bimm, rs2, rs1, branch_f3[n]), pc, 1'b0,
                    rs1, rs2, 1'b1, 1'b0, '0, rf[rs1], rf[rs2], pc, sext13(bimm));
        end
        // jal then jalr back to back, each result one cycle after its edge
        rs1  = reg_addr_t'($random(seed));
        rd   = reg_addr_t'($random(seed));
        rd2  = reg_addr_t'($random(seed));
        jimm = 21'($random(seed)) & ~21'h1;
        imm  = 12'($random(seed));
        pc   = xlen_t'($random(seed)) & ~32'h3;
        @(posedge clk);
        inst_valid <= 1'b1;
        inst_word  <= enc_j(jimm, rd);
        inst_addr  <= pc;
        @(negedge clk);
        check_addr("reg1_raddr_o", reg1_raddr, '0);
        check_addr("reg2_raddr_o", reg2_raddr, '0);
        @(posedge clk);
        inst_word <= enc_i(OPC_JALR, imm, rs1, 3'b000, rd2);
        inst_addr <= pc + INST_LEN;
        @(negedge clk);
        check_result(1'b1, 1'b1, rd, pc, INST_LEN, pc, sext21(jimm));
        check_word("inst_addr_o", inst_addr_out, pc);
        check_addr("reg1_raddr_o", reg1_raddr, rs1);
        check_addr("reg2_raddr_o", reg2_raddr, '0);
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        check_result(1'b1, 1'b1, rd2, pc + INST_LEN, INST_LEN, rf[rs1], sext12(imm));
        check_word("inst_addr_o", inst_addr_out, pc + INST_LEN);
    endtask

    task automatic test_upper();
        reg_addr_t   rd;
        logic [19:0] uimm;
        xlen_t       pc;
        for (int n = 0; n < 4; n++) begin
            rd   = reg_addr_t'($random(seed));
            uimm = 20'($random(seed));
            pc   = xlen_t'($random(seed)) & ~32'h3;
            run_one(enc_u(OPC_LUI, uimm, rd), pc, 1'b0,
                    '0, '0, 1'b1, 1'b1, rd, {uimm, 12'h000}, '0, '0, '0);
            run_one(enc_u(OPC_AUIPC, uimm, rd), pc, 1'b0,
                    '0, '0, 1'b1, 1'b1, rd, pc, {uimm, 12'h000}, '0, '0);
        end
    endtask

    task automatic test_bubbles();
        reg_addr_t rs1;
        reg_addr_t rs2;
        xlen_t     pc;
        rs1 = reg_addr_t'($random(seed));
        rs2 = reg_addr_t'($random(seed));
        pc  = xlen_t'($random(seed)) & ~32'h3;
        // flush drops the instruction entirely
        run_one(enc_r(7'h00, rs2, rs1, 3'b000, 5'd3), pc, 1'b1,
                rs1, rs2, 1'b0, 1'b0, '0, '0, '0, '0, '0);
        // fence opcode is not decoded here
        run_one(enc_i(7'b0001111, 12'h0ff, rs1, 3'b000, 5'd4), pc, 1'b0,
                '0, '0, 1'b1, 1'b0, '0, '0, '0, '0, '0);
        run_one(enc_s(12'h123, rs2, rs1, 3'b011), pc, 1'b0,
                '0, '0, 1'b1, 1'b0, '0, '0, '0, '0, '0);
    endtask

    initial begin
        seed = 7816;
        for (int r = 0; r < 32; r++) begin
            rf[r] = $random(seed);
        end
        rf[0] = '0;
        arst_n       <= 1'b0;
        inst_valid   <= 1'b0;
        inst_word    <= '0;
        inst_addr    <= '0;
        ex_jump_flag <= 1'b0;
        test_reset();
        test_alu();
        test_load_store();
        test_jumps();
        test_upper();
        test_bubbles();
        $display("Regression passed");
        $finish;
    end

endmodule

/* design/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode
    import decode_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    // from fetch
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  xlen_t     inst_addr_i,
    // from register file
    input  xlen_t     reg1_rdata_i,
    input  xlen_t     reg2_rdata_i,
    // from execute
    input  logic      ex_jump_flag_i,
    // to register file, same cycle
    output reg_addr_t reg1_raddr_o,
    output reg_addr_t reg2_raddr_o,
    // to execute, one cycle later
    output logic      valid_o,
    output logic      reg_wen_o,
    output reg_addr_t reg_waddr_o,
    output xlen_t     op1_o,
    output xlen_t     op2_o,
    output xlen_t     op1_jump_o,
    output xlen_t     op2_jump_o,
    output inst_t     inst_o,
    output xlen_t     inst_addr_o
);

    reg_addr_t rd;
    logic      reg_wen;
    imm_kind_e imm_kind;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    jmp_sel_e  jmp_sel;
    xlen_t     imm;

    ctrl_decode i_ctrl_decode (
        .inst_i       (inst_i),
        .reg1_raddr_o (reg1_raddr_o),
        .reg2_raddr_o (reg2_raddr_o),
        .rd_o         (rd),
        .reg_wen_o    (reg_wen),
        .imm_kind_o   (imm_kind),
        .op1_sel_o    (op1_sel),
        .op2_sel_o    (op2_sel),
        .jmp_sel_o    (jmp_sel)
    );

    imm_gen i_imm_gen (
        .inst_i     (inst_i),
        .imm_kind_i (imm_kind),
        .imm_o      (imm)
    );

    operand_select i_operand_select (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_addr_i    (inst_addr_i),
        .ex_jump_flag_i (ex_jump_flag_i),
        .reg1_rdata_i   (reg1_rdata_i),
        .reg2_rdata_i   (reg2_rdata_i),
        .imm_i          (imm),
        .rd_i           (rd),
        .reg_wen_i      (reg_wen),
        .op1_sel_i      (op1_sel),
        .op2_sel_i      (op2_sel),
        .jmp_sel_i      (jmp_sel),
        .valid_o        (valid_o),
        .reg_wen_o      (reg_wen_o),
        .reg_waddr_o    (reg_waddr_o),
        .op1_o          (op1_o),
        .op2_o          (op2_o),
        .op1_jump_o     (op1_jump_o),
        .op2_jump_o     (op2_jump_o),
        .inst_o         (inst_o),
        .inst_addr_o    (inst_addr_o)
    );

endmodule

/* design/operand_select.sv */
`timescale 1ns/1ps

module operand_select
    import decode_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    // from fetch
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  xlen_t     inst_addr_i,
    // from execute
    input  logic      ex_jump_flag_i,
    // from register file
    input  xlen_t     reg1_rdata_i,
    input  xlen_t     reg2_rdata_i,
    // from decoders
    input  xlen_t     imm_i,
    input  reg_addr_t rd_i,
    input  logic      reg_wen_i,
    input  op1_sel_e  op1_sel_i,
    input  op2_sel_e  op2_sel_i,
    input  jmp_sel_e  jmp_sel_i,
    // to execute
    output logic      valid_o,
    output logic      reg_wen_o,
    output reg_addr_t reg_waddr_o,
    output xlen_t     op1_o,
    output xlen_t     op2_o,
    output xlen_t     op1_jump_o,
    output xlen_t     op2_jump_o,
    output inst_t     inst_o,
    output xlen_t     inst_addr_o
);

    xlen_t op1;
    xlen_t op2;
    xlen_t op1_jump;
    xlen_t op2_jump;
    logic  bubble;

    always_comb begin
        case (op1_sel_i)
            OP1_RS1: op1 = reg1_rdata_i;
            OP1_PC:  op1 = inst_addr_i;
            OP1_IMM: op1 = imm_i;
            default: op1 = '0;
        endcase

        case (op2_sel_i)
            OP2_RS2:  op2 = reg2_rdata_i;
            OP2_IMM:  op2 = imm_i;
            OP2_FOUR: op2 = INST_LEN;
            default:  op2 = '0;
        endcase

        // jump target base and offset
        case (jmp_sel_i)
            JMP_PC_IMM: begin
                op1_jump = inst_addr_i;
                op2_jump = imm_i;
            end
            JMP_RS1_IMM: begin
                op1_jump = reg1_rdata_i;
                op2_jump = imm_i;
            end
            default: begin
                op1_jump = '0;
                op2_jump = '0;
            end
        endcase
    end

    // nothing taken this cycle, or execute is redirecting
    assign bubble = ex_jump_flag_i || !inst_valid_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o     <= 1'b0;
            reg_wen_o   <= 1'b0;
            reg_waddr_o <= '0;
            op1_o       <= '0;
            op2_o       <= '0;
            op1_jump_o  <= '0;
            op2_jump_o  <= '0;
        end else if (bubble) begin
            valid_o     <= 1'b0;
            reg_wen_o   <= 1'b0;
            reg_waddr_o <= '0;
            op1_o       <= '0;
            op2_o       <= '0;
            op1_jump_o  <= '0;
            op2_jump_o  <= '0;
        end else begin
            // illegal encodings arrive here with zero selects
            valid_o     <= 1'b1;
            reg_wen_o   <= reg_wen_i;
            reg_waddr_o <= reg_wen_i ? rd_i : '0;
            op1_o       <= op1;
            op2_o       <= op2;
            op1_jump_o  <= op1_jump;
            op2_jump_o  <= op2_jump;
        end
    end

    // instruction word and address follow each taken instruction
    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            inst_o      <= inst_i;
            inst_addr_o <= inst_addr_i;
        end
    end

endmodule

/* design/imm_gen.sv */
`timescale 1ns/1ps

module imm_gen
    import decode_pkg::*;
(
    input  inst_t     inst_i,
    input  imm_kind_e imm_kind_i,
    output xlen_t     imm_o
);

    // sign bit is always inst[31]
    logic sign;

    assign sign = inst_i[31];

    always_comb begin
        case (imm_kind_i)
            IMM_I: begin
                imm_o = {{20{sign}}, inst_i[31:20]};
            end
            IMM_S: begin
                // split field, upper part in funct7 position
                imm_o = {{20{sign}}, inst_i[31:25], inst_i[11:7]};
            end
            IMM_B: begin
                imm_o = {{19{sign}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {inst_i[31:12], 12'b0};
            end
            IMM_J: begin
                // offset in units of 2 bytes
                imm_o = {{11{sign}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

/* design/ctrl_decode.sv */
`timescale 1ns/1ps

module ctrl_decode
    import decode_pkg::*;
(
    input  inst_t     inst_i,
    // to register file
    output reg_addr_t reg1_raddr_o,
    output reg_addr_t reg2_raddr_o,
    // write-back control
    output reg_addr_t rd_o,
    output logic      reg_wen_o,
    // to imm_gen and operand_select
    output imm_kind_e imm_kind_o,
    output op1_sel_e  op1_sel_o,
    output op2_sel_e  op2_sel_o,
    output jmp_sel_e  jmp_sel_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    reg_addr_t  rd;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign rd     = inst_i[11:7];

    always_comb begin
        // anything not matched below decodes as a bubble
        reg1_raddr_o = '0;
        reg2_raddr_o = '0;
        rd_o         = '0;
        reg_wen_o    = 1'b0;
        imm_kind_o   = IMM_I;
        op1_sel_o    = OP1_ZERO;
        op2_sel_o    = OP2_ZERO;
        jmp_sel_o    = JMP_NONE;

        case (opcode)
            OPC_R_TYPE: begin
                // every funct3 is a valid ALU op
                reg1_raddr_o = rs1;
                reg2_raddr_o = rs2;
                rd_o         = rd;
                reg_wen_o    = 1'b1;
                op1_sel_o    = OP1_RS1;
                op2_sel_o    = OP2_RS2;
            end
            OPC_I_TYPE: begin
                reg1_raddr_o = rs1;
                rd_o         = rd;
                reg_wen_o    = 1'b1;
                imm_kind_o   = IMM_I;
                op1_sel_o    = OP1_RS1;
                op2_sel_o    = OP2_IMM;
            end
            OPC_LOAD: begin
                if (funct3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
                    // base plus offset, data comes back to rd
                    reg1_raddr_o = rs1;
                    rd_o         = rd;
                    reg_wen_o    = 1'b1;
                    imm_kind_o   = IMM_I;
                    op1_sel_o    = OP1_RS1;
                    op2_sel_o    = OP2_IMM;
                end
            end
            OPC_STORE: begin
                if (funct3 inside {F3_SB, F3_SH, F3_SW}) begin
                    // rs2 is read for the store data, no write-back
                    reg1_raddr_o = rs1;
                    reg2_raddr_o = rs2;
                    imm_kind_o   = IMM_S;
                    op1_sel_o    = OP1_RS1;
                    op2_sel_o    = OP2_IMM;
                end
            end
            OPC_BRANCH: begin
                if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    // compare rs1 with rs2, target is pc + offset
                    reg1_raddr_o = rs1;
                    reg2_raddr_o = rs2;
                    imm_kind_o   = IMM_B;
                    op1_sel_o    = OP1_RS1;
                    op2_sel_o    = OP2_RS2;
                    jmp_sel_o    = JMP_PC_IMM;
                end
            end
            OPC_LUI: begin
                rd_o       = rd;
                reg_wen_o  = 1'b1;
                imm_kind_o = IMM_U;
                op1_sel_o  = OP1_IMM;
                op2_sel_o  = OP2_ZERO;
            end
            OPC_AUIPC: begin
                rd_o       = rd;
                reg_wen_o  = 1'b1;
                imm_kind_o = IMM_U;
                op1_sel_o  = OP1_PC;
                op2_sel_o  = OP2_IMM;
            end
            OPC_JAL: begin
                // link value is pc + 4
                rd_o       = rd;
                reg_wen_o  = 1'b1;
                imm_kind_o = IMM_J;
                op1_sel_o  = OP1_PC;
                op2_sel_o  = OP2_FOUR;
                jmp_sel_o  = JMP_PC_IMM;
            end
            OPC_JALR: begin
                reg1_raddr_o = rs1;
                rd_o         = rd;
                reg_wen_o    = 1'b1;
                imm_kind_o   = IMM_I;
                op1_sel_o    = OP1_PC;
                op2_sel_o    = OP2_FOUR;
                jmp_sel_o    = JMP_RS1_IMM;
            end
            default: begin
                // unknown opcode, keep the bubble
            end
        endcase
    end

endmodule

/* design/decode_pkg.sv */
package decode_pkg;

    // basic word types
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    // RV32I major opcodes kept by this stage
    typedef enum logic [6:0] {
        OPC_R_TYPE = 7'b0110011,
        OPC_I_TYPE = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    // load widths
    localparam logic [2:0] F3_LB   = 3'b000;
    localparam logic [2:0] F3_LH   = 3'b001;
    localparam logic [2:0] F3_LW   = 3'b010;
    localparam logic [2:0] F3_LBU  = 3'b100;
    localparam logic [2:0] F3_LHU  = 3'b101;

    // store widths
    localparam logic [2:0] F3_SB   = 3'b000;
    localparam logic [2:0] F3_SH   = 3'b001;
    localparam logic [2:0] F3_SW   = 3'b010;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // immediate formats
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_kind_e;

    // operand sources, zero first so an all-zero select is a bubble
    typedef enum logic [1:0] {OP1_ZERO, OP1_RS1, OP1_PC, OP1_IMM} op1_sel_e;
    typedef enum logic [1:0] {OP2_ZERO, OP2_RS2, OP2_IMM, OP2_FOUR} op2_sel_e;

    // jump target operand pairs
    typedef enum logic [1:0] {
        JMP_NONE,
        JMP_PC_IMM,
        JMP_RS1_IMM
    } jmp_sel_e;

    // link offset for jal and jalr
    localparam xlen_t INST_LEN = 32'd4;

endpackage
